/* ptw_input.txt */
# M word_addr pte : page-table word, word_addr is the physical address divided by 4
# R vaddr store instr mxr is_fault result : miss and its expected 32-bit result word
M 00020000 00020401
M 00020001 001000CF
M 00020002 001004CF
M 00020003 00048C00
M 00020400 048D14DF
M 00020401 00015405
M 00020402 00019801
M 00020403 0001DC49
M 00020404 00022043
M 00020405 00026447
M 00020406 0002A88F
R 00000123 0 0 0 0 048D15F8
R 00400000 0 0 0 0 001003B8
R 00800000 0 0 0 1 4001004C
R 00001000 0 0 0 1 30001540
R 00000789 1 0 0 0 048D15F8
R 00C00000 0 0 0 1 200048C0
R 00002000 0 0 0 1 70001980
R 00003000 0 1 0 0 0001DCA0
R 00003004 0 0 0 1 90001DC4
R 00004000 1 0 0 1 90002204
R 00005000 1 0 0 1 90002644
R 00006000 0 1 0 1 90002A88
R 00003008 0 0 1 0 0001DCA0

/* vlog.f */
ptw_pkg.sv
ptw_miss_dispatch.sv
ptw_walker.sv
ptw_mem_arbiter.sv
ptw_result_collect.sv
ptw_cluster.sv
ptw_cluster_assertions.sv
tb_ptw_cluster.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ptw_cluster
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* tb_ptw_cluster.sv */
module tb_ptw_cluster;

  localparam int NUM_WALKERS = 4;
  localparam int RES_CREDITS = 2;
  // root page table at physical 0x80000
  localparam logic [ptw_pkg::PPNW-1:0] SATP_PPN = 22'h000080;

  logic                     clk_i;
  logic                     rst_ni;
  logic [ptw_pkg::PPNW-1:0] satp_ppn_i;
  logic                     mxr_i;
  logic                     miss_valid_i;
  logic [ptw_pkg::VLEN-1:0] miss_vaddr_i;
  logic                     miss_store_i;
  logic                     miss_instr_i;
  logic                     miss_credit_o;
  logic                     mem_req_o;
  logic [ptw_pkg::PLEN-1:0] mem_addr_o;
  logic                     mem_gnt_i;
  logic                     mem_rvalid_i;
  logic [31:0]              mem_rdata_i;
  logic                     result_valid_o;
  ptw_pkg::walk_result_u    result_o;
  logic                     result_fault_o;
  logic [ptw_pkg::VLEN-1:0] result_vaddr_o;
  logic                     res_credit_i;

  // page table, keyed by word address
  logic [31:0]              pt_mem [logic [31:0]];
  // expected walks in file order
  logic [ptw_pkg::VLEN-1:0] req_vaddr [$];
  logic                     req_store [$];
  logic                     req_instr [$];
  logic                     req_mxr [$];
  logic                     req_fault [$];
  ptw_pkg::walk_result_u    req_result [$];
  bit                       seen [$];

  int miss_credits = NUM_WALKERS;
  int credits_back = 0;
  int results_got  = 0;
  // results received but not yet answered with a credit
  int owed_credits = 0;
  bit hold_credits = 1'b1;
  bit loaded       = 1'b0;

  ptw_cluster #(
    .NUM_WALKERS(NUM_WALKERS),
    .RES_CREDITS(RES_CREDITS)
  ) ptw_cluster_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .satp_ppn_i    (satp_ppn_i),
    .mxr_i         (mxr_i),
    .miss_valid_i  (miss_valid_i),
    .miss_vaddr_i  (miss_vaddr_i),
    .miss_store_i  (miss_store_i),
    .miss_instr_i  (miss_instr_i),
    .miss_credit_o (miss_credit_o),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .mem_gnt_i     (mem_gnt_i),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i),
    .result_valid_o(result_valid_o),
    .result_o      (result_o),
    .result_fault_o(result_fault_o),
    .result_vaddr_o(result_vaddr_o),
    .res_credit_i  (res_credit_i)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // ------------------------------
  // helpers and compare tasks
  // ------------------------------
  task automatic abort_run(input string why);
    $display("Test failed");
    $fatal(1, why);
  endtask

  // inputs change 10 units after the rising edge
  task automatic wait_drive_slot();
    @(posedge clk_i);
    #10;
  endtask

  task automatic check_result(input string name, input ptw_pkg::walk_result_u exp,
                              input ptw_pkg::walk_result_u act);
    if (act !== exp) begin
      $display("FAILED %s: expected %08h, actual %08h", name, exp, act);
      abort_run("result word mismatch");
    end
  endtask

  task automatic check_fault(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s: expected is_fault %0b, actual %0b", name, exp, act);
      abort_run("fault flag mismatch");
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
      abort_run("count mismatch");
    end
  endtask

  function automatic int find_request(input logic [ptw_pkg::VLEN-1:0] vaddr);
    for (int i = 0; i < req_vaddr.size(); i++) begin
      if (req_vaddr[i] == vaddr) return i;
    end
    return -1;
  endfunction

  task automatic read_pte(input logic [ptw_pkg::PLEN-1:0] addr, output logic [31:0] word);
    if (!pt_mem.exists(addr[33:2])) begin
      $display("page-table read from unmapped address %09h", addr);
      abort_run("unmapped page-table read");
    end else begin
      word = pt_mem[addr[33:2]];
    end
  endtask

  // M lines fill the page table, R lines are misses with expected results
  task automatic load_input();
    int                    fd;
    int                    n;
    string                 line;
    logic [31:0]           a;
    logic [31:0]           d;
    int                    st;
    int                    ins;
    int                    mx;
    int                    fl;
    ptw_pkg::walk_result_u res_word;
    fd = $fopen("ptw_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open ptw_input.txt");
      abort_run("missing input file");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() > 1 && line.getc(0) == "M") begin
        n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, d);
        if (n != 2) abort_run("malformed memory line in ptw_input.txt");
        pt_mem[a] = d;
      end else if (line.len() > 1 && line.getc(0) == "R") begin
        n = $sscanf(line.substr(1, line.len() - 1), "%h %d %d %d %d %h",
                    a, st, ins, mx, fl, d);
        if (n != 6) abort_run("malformed request line in ptw_input.txt");
        res_word = d;
        req_vaddr.push_back(a);
        req_store.push_back(st != 0);
        req_instr.push_back(ins != 0);
        req_mxr.push_back(mx != 0);
        req_fault.push_back(fl != 0);
        req_result.push_back(res_word);
        seen.push_back(1'b0);
      end
    end
    $fclose(fd);
  endtask

  task automatic send_miss(input int idx);
    // one miss credit per miss
    while (miss_credits == 0) wait_drive_slot();
    miss_valid_i = 1'b1;
    miss_vaddr_i = req_vaddr[idx];
    miss_store_i = req_store[idx];
    miss_instr_i = req_instr[idx];
    miss_credits--;
    wait_drive_slot();
    miss_valid_i = 1'b0;
  endtask

  // ------------------------------
  // memory model and consumer
  // ------------------------------
  initial begin : environment
    int          seed;
    int          gnt_delay;
    int          credit_delay;
    logic [31:0] gnt_word;
    seed         = $urandom(89223);
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    res_credit_i = 1'b0;
    gnt_word     = '0;
    gnt_delay    = -1;
    credit_delay = $urandom_range(3, 0);
    forever begin
      wait_drive_slot();
      // read data follows the grant by one cycle
      mem_rvalid_i = mem_gnt_i;
      mem_rdata_i  = mem_gnt_i ? gnt_word : '0;
      mem_gnt_i    = 1'b0;
      if (rst_ni && mem_req_o) begin
        if (gnt_delay < 0) gnt_delay = $urandom_range(3, 0);
        if (gnt_delay == 0) begin
          mem_gnt_i = 1'b1;
          read_pte(mem_addr_o, gnt_word);
          gnt_delay = -1;
        end else begin
          gnt_delay--;
        end
      end
      // consumer hands back one credit per result after a random wait
      res_credit_i = 1'b0;
      if (!hold_credits && owed_credits > 0) begin
        if (credit_delay == 0) begin
          res_credit_i = 1'b1;
          owed_credits--;
          credit_delay = $urandom_range(3, 0);
        end else begin
          credit_delay--;
        end
      end
    end
  end

  // outputs sampled mid cycle
  always @(negedge clk_i) begin : monitor
    int    idx;
    string name;
    if (rst_ni) begin
      if (miss_credit_o) begin
        miss_credits++;
        credits_back++;
      end
      if (result_valid_o) begin
        idx = find_request(result_vaddr_o);
        if (idx < 0) begin
          $display("result for unknown vaddr %08h", result_vaddr_o);
          abort_run("unexpected result");
        end else if (seen[idx]) begin
          $display("second result for vaddr %08h", result_vaddr_o);
          abort_run("duplicate result");
        end else begin
          name = $sformatf("walk %08h", req_vaddr[idx]);
          check_fault(name, req_fault[idx], result_fault_o);
          check_result(name, req_result[idx], result_o);
          seen[idx] = 1'b1;
          results_got++;
          owed_credits++;
        end
      end
      // miss credit and result leave the same pop
      check_count("miss credits per result", results_got, credits_back);
    end
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin : stimulus
    rst_ni       = 1'b0;
    satp_ppn_i   = SATP_PPN;
    mxr_i        = 1'b0;
    miss_valid_i = 1'b0;
    miss_vaddr_i = '0;
    miss_store_i = 1'b0;
    miss_instr_i = 1'b0;
    load_input();
    loaded = 1'b1;
    mxr_i  = req_mxr[0];
    repeat (5) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    wait_drive_slot();
    // back to back misses, consumer keeps its credits
    for (int i = 0; i < NUM_WALKERS; i++) send_miss(i);
    while (results_got < RES_CREDITS) wait_drive_slot();
    repeat (50) @(posedge clk_i);
    #10;
    check_count("results while credits held", RES_CREDITS, results_got);
    hold_credits = 1'b0;
    for (int i = NUM_WALKERS; i < req_vaddr.size(); i++) begin
      // mxr is quasi-static, so drain the cluster before changing it
      if (req_mxr[i] != mxr_i) begin
        while (results_got != i) wait_drive_slot();
        mxr_i = req_mxr[i];
      end
      send_miss(i);
    end
    while (results_got != req_vaddr.size()) wait_drive_slot();
    // stray results after the last walk still reach the monitor
    repeat (10) @(posedge clk_i);
    #10;
    $display("Test passed");
    $finish;
  end

  // 300 cycles for each walk in the file
  initial begin : watchdog
    wait (loaded);
    repeat (300 * req_vaddr.size()) @(posedge clk_i);
    $display("timeout after %0d walks of %0d", results_got, req_vaddr.size());
    abort_run("timeout");
  end

endmodule

/* ptw_cluster_assertions.sv */
module ptw_cluster_assertions #(
  parameter int NUM_WALKERS = 4,
  parameter int RES_CREDITS = 2
) (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic [NUM_WALKERS-1:0] start_i,
  input logic [NUM_WALKERS-1:0] busy_i,
  input logic [NUM_WALKERS-1:0] pop_i,
  input logic                   mem_req_i,
  input logic                   mem_gnt_i,
  input logic                   result_valid_i,
  input logic                   res_credit_i
);

  // consumer credits not yet used by a result
  int credits_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credits_q <= RES_CREDITS;
    end else begin
      credits_q <= credits_q + int'(res_credit_i) - int'(result_valid_i);
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) result_valid_i |-> credits_q > 0)
    else $error("result sent without a consumer credit");

  assert property (@(posedge clk_i) disable iff (!rst_ni) (start_i & busy_i) == '0)
    else $error("start sent to a busy walker");

  // request holds until its grant
  assert property (@(posedge clk_i) disable iff (!rst_ni) mem_req_i && !mem_gnt_i |=> mem_req_i)
    else $error("memory request dropped before grant");

  assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(pop_i))
    else $error("more than one walker popped");

endmodule

bind ptw_cluster ptw_cluster_assertions #(
  .NUM_WALKERS(NUM_WALKERS),
  .RES_CREDITS(RES_CREDITS)
) assertions_inst (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .start_i       (start),
  .busy_i        (busy),
  .pop_i         (pop),
  .mem_req_i     (mem_req_o),
  .mem_gnt_i     (mem_gnt_i),
  .result_valid_i(result_valid_o),
  .res_credit_i  (res_credit_i)
);

/* ptw_cluster.sv */
module ptw_cluster #(
  parameter int NUM_WALKERS = 4,
  parameter int RES_CREDITS = 2
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [ptw_pkg::PPNW-1:0] satp_ppn_i,
  input  logic                     mxr_i,
  // miss side
  input  logic                     miss_valid_i,
  input  logic [ptw_pkg::VLEN-1:0] miss_vaddr_i,
  input  logic                     miss_store_i,
  input  logic                     miss_instr_i,
  output logic                     miss_credit_o,
  // page table memory
  output logic                     mem_req_o,
  output logic [ptw_pkg::PLEN-1:0] mem_addr_o,
  input  logic                     mem_gnt_i,
  input  logic                     mem_rvalid_i,
  input  logic [31:0]              mem_rdata_i,
  // result side
  output logic                     result_valid_o,
  output ptw_pkg::walk_result_u    result_o,
  output logic                     result_fault_o,
  output logic [ptw_pkg::VLEN-1:0] result_vaddr_o,
  input  logic                     res_credit_i
);

  // dispatcher to walkers
  logic [NUM_WALKERS-1:0]   start;
  logic [NUM_WALKERS-1:0]   busy;
  logic [ptw_pkg::VLEN-1:0] start_vaddr;
  logic                     start_store;
  logic                     start_instr;
  // walkers to arbiter
  logic [NUM_WALKERS-1:0]   walk_req;
  logic [ptw_pkg::PLEN-1:0] walk_addr [NUM_WALKERS];
  logic [NUM_WALKERS-1:0]   walk_gnt;
  logic [NUM_WALKERS-1:0]   walk_rvalid;
  logic [31:0]              walk_rdata;
  // walkers to collector
  logic [NUM_WALKERS-1:0]   done;
  ptw_pkg::walk_result_u    walk_result [NUM_WALKERS];
  logic [NUM_WALKERS-1:0]   walk_fault;
  logic [ptw_pkg::VLEN-1:0] walk_vaddr [NUM_WALKERS];
  logic [NUM_WALKERS-1:0]   pop;

  ptw_miss_dispatch #(
    .NUM_WALKERS(NUM_WALKERS)
  ) dispatch_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .miss_valid_i (miss_valid_i),
    .miss_vaddr_i (miss_vaddr_i),
    .miss_store_i (miss_store_i),
    .miss_instr_i (miss_instr_i),
    .walker_busy_i(busy),
    .walker_pop_i (pop),
    .start_o      (start),
    .start_vaddr_o(start_vaddr),
    .start_store_o(start_store),
    .start_instr_o(start_instr),
    .miss_credit_o(miss_credit_o)
  );

  // ------------------------------
  // walker array
  // ------------------------------
  for (genvar g = 0; g < NUM_WALKERS; g++) begin : gen_walker
    ptw_walker walker_inst (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .start_i     (start[g]),
      .vaddr_i     (start_vaddr),
      .store_i     (start_store),
      .instr_i     (start_instr),
      .satp_ppn_i  (satp_ppn_i),
      .mxr_i       (mxr_i),
      .busy_o      (busy[g]),
      .mem_req_o   (walk_req[g]),
      .mem_addr_o  (walk_addr[g]),
      .mem_gnt_i   (walk_gnt[g]),
      .mem_rvalid_i(walk_rvalid[g]),
      .mem_rdata_i (walk_rdata),
      .done_o      (done[g]),
      .result_o    (walk_result[g]),
      .is_fault_o  (walk_fault[g]),
      .vaddr_o     (walk_vaddr[g]),
      .pop_i       (pop[g])
    );
  end

  ptw_mem_arbiter #(
    .NUM_WALKERS(NUM_WALKERS)
  ) arbiter_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (walk_req),
    .addr_i      (walk_addr),
    .gnt_o       (walk_gnt),
    .rvalid_o    (walk_rvalid),
    .rdata_o     (walk_rdata),
    .mem_req_o   (mem_req_o),
    .mem_addr_o  (mem_addr_o),
    .mem_gnt_i   (mem_gnt_i),
    .mem_rvalid_i(mem_rvalid_i),
    .mem_rdata_i (mem_rdata_i)
  );

  ptw_result_collect #(
    .NUM_WALKERS(NUM_WALKERS),
    .RES_CREDITS(RES_CREDITS)
  ) collect_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .done_i        (done),
    .result_i      (walk_result),
    .is_fault_i    (walk_fault),
    .vaddr_i       (walk_vaddr),
    .pop_o         (pop),
    .result_valid_o(result_valid_o),
    .result_o      (result_o),
    .result_fault_o(result_fault_o),
    .result_vaddr_o(result_vaddr_o),
    .res_credit_i  (res_credit_i)
  );

endmodule

/* ptw_result_collect.sv */
module ptw_result_collect #(
  parameter int NUM_WALKERS = 4,
  parameter int RES_CREDITS = 2
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [NUM_WALKERS-1:0]   done_i,
  input  ptw_pkg::walk_result_u    result_i [NUM_WALKERS],
  input  logic [NUM_WALKERS-1:0]   is_fault_i,
  input  logic [ptw_pkg::VLEN-1:0] vaddr_i [NUM_WALKERS],
  output logic [NUM_WALKERS-1:0]   pop_o,
  output logic                     result_valid_o,
  output ptw_pkg::walk_result_u    result_o,
  output logic                     result_fault_o,
  output logic [ptw_pkg::VLEN-1:0] result_vaddr_o,
  input  logic                     res_credit_i
);

  localparam int IDXW = (NUM_WALKERS > 1) ? $clog2(NUM_WALKERS) : 1;
  // counter holds 0 to RES_CREDITS
  localparam int CW   = $clog2(RES_CREDITS + 1);

  logic [CW-1:0]            credit_q;
  logic [IDXW-1:0]          rr_q;
  logic [IDXW-1:0]          win;
  logic                     found;
  logic                     send;
  logic                     valid_q;
  ptw_pkg::walk_result_u    result_q;
  logic                     fault_q;
  logic [ptw_pkg::VLEN-1:0] vaddr_q;

  // round robin over finished walkers
  always_comb begin
    int idx;
    found = 1'b0;
    win   = '0;
    for (int k = 0; k < NUM_WALKERS; k++) begin
      idx = (int'(rr_q) + k) % NUM_WALKERS;
      if (!found && done_i[idx]) begin
        found = 1'b1;
        win   = IDXW'(idx);
      end
    end
  end

  // drain only while the consumer has room
  assign send = found && (credit_q != '0);

  always_comb begin
    pop_o      = '0;
    pop_o[win] = send;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= CW'(RES_CREDITS);
      rr_q     <= '0;
      valid_q  <= 1'b0;
    end else begin
      credit_q <= credit_q + CW'(res_credit_i) - CW'(send);
      valid_q  <= send;
      if (send) rr_q <= (win == IDXW'(NUM_WALKERS - 1)) ? '0 : win + 1'b1;
    end
  end

  // output payload
  always_ff @(posedge clk_i) begin
    if (send) begin
      result_q <= result_i[win];
      fault_q  <= is_fault_i[win];
      vaddr_q  <= vaddr_i[win];
    end
  end

  assign result_valid_o = valid_q;
  assign result_o       = result_q;
  assign result_fault_o = fault_q;
  assign result_vaddr_o = vaddr_q;

endmodule

/* ptw_mem_arbiter.sv */
module ptw_mem_arbiter #(
  parameter int NUM_WALKERS = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [NUM_WALKERS-1:0]   req_i,
  input  logic [ptw_pkg::PLEN-1:0] addr_i [NUM_WALKERS],
  output logic [NUM_WALKERS-1:0]   gnt_o,
  output logic [NUM_WALKERS-1:0]   rvalid_o,
  output logic [31:0]              rdata_o,
  output logic                     mem_req_o,
  output logic [ptw_pkg::PLEN-1:0] mem_addr_o,
  input  logic                     mem_gnt_i,
  input  logic                     mem_rvalid_i,
  input  logic [31:0]              mem_rdata_i
);

  localparam int IDXW = (NUM_WALKERS > 1) ? $clog2(NUM_WALKERS) : 1;

  logic [IDXW-1:0] rr_q;
  logic [IDXW-1:0] scan_win;
  logic [IDXW-1:0] win;
  logic [IDXW-1:0] lock_idx_q;
  logic [IDXW-1:0] owner_q;
  logic            lock_q;
  logic            found;

  // round robin scan starting at rr_q
  always_comb begin
    int idx;
    found    = 1'b0;
    scan_win = '0;
    for (int k = 0; k < NUM_WALKERS; k++) begin
      idx = (int'(rr_q) + k) % NUM_WALKERS;
      if (!found && req_i[idx]) begin
        found    = 1'b1;
        scan_win = IDXW'(idx);
      end
    end
  end

  // keep the winner stable while its grant is outstanding
  assign win        = lock_q ? lock_idx_q : scan_win;
  assign mem_req_o  = found;
  assign mem_addr_o = addr_i[win];
  assign rdata_o    = mem_rdata_i;

  always_comb begin
    gnt_o           = '0;
    gnt_o[win]      = mem_gnt_i & found;
    // rvalid belongs to the walker granted one cycle earlier
    rvalid_o        = '0;
    rvalid_o[owner_q] = mem_rvalid_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q       <= '0;
      owner_q    <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (found && mem_gnt_i) begin
      // advance past the granted walker
      rr_q    <= (win == IDXW'(NUM_WALKERS - 1)) ? '0 : win + 1'b1;
      owner_q <= win;
      lock_q  <= 1'b0;
    end else if (found) begin
      lock_q     <= 1'b1;
      lock_idx_q <= win;
    end
  end

endmodule

/* ptw_walker.sv */
module ptw_walker (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     start_i,
  input  logic [ptw_pkg::VLEN-1:0] vaddr_i,
  input  logic                     store_i,
  input  logic                     instr_i,
  input  logic [ptw_pkg::PPNW-1:0] satp_ppn_i,
  input  logic                     mxr_i,
  output logic                     busy_o,
  output logic                     mem_req_o,
  output logic [ptw_pkg::PLEN-1:0] mem_addr_o,
  input  logic                     mem_gnt_i,
  input  logic                     mem_rvalid_i,
  input  logic [31:0]              mem_rdata_i,
  output logic                     done_o,
  output ptw_pkg::walk_result_u    result_o,
  output logic                     is_fault_o,
  output logic [ptw_pkg::VLEN-1:0] vaddr_o,
  input  logic                     pop_i
);

  localparam logic [2:0] S_IDLE    = 3'd0;
  localparam logic [2:0] S_REQUEST = 3'd1;
  localparam logic [2:0] S_LOOKUP  = 3'd2;
  localparam logic [2:0] S_ERROR   = 3'd3;
  localparam logic [2:0] S_DONE    = 3'd4;

  logic [2:0]                  state_q, state_d;
  // 0 first level, 1 second level
  logic                        lvl_q, lvl_d;
  logic [ptw_pkg::PLEN-1:0]    pptr_q, pptr_d;
  logic [ptw_pkg::VLEN-1:0]    vaddr_q;
  logic                        store_q;
  logic                        instr_q;
  logic                        rvalid_q;
  logic [31:0]                 rdata_q;
  ptw_pkg::walk_result_u       result_q, result_d;
  logic                        fault_q, fault_d;
  ptw_pkg::pte_t               pte;
  logic                        is_leaf;
  logic                        misaligned;
  logic                        perm_ok;
  logic                        go_next;
  logic                        take_fault;
  ptw_pkg::fault_cause_e       cause;
  ptw_pkg::xlat_t              xlat_v;
  ptw_pkg::fault_t             fault_v;

  assign pte = ptw_pkg::pte_t'(rdata_q);

  // ------------------------------
  // pte checks
  // ------------------------------
  // r or x set marks a leaf, otherwise a pointer
  assign is_leaf    = pte.r | pte.x;
  // 4 MiB leaf must have its low ppn clear
  assign misaligned = !lvl_q && (pte.ppn[9:0] != '0);

  // a/d bits are left to software, so missing ones fault
  always_comb begin
    if (instr_q) begin
      perm_ok = pte.x & pte.a;
    end else begin
      // no write-only pages, mxr lets loads read executable pages
      perm_ok = pte.a & (pte.r | (pte.x & mxr_i)) & (!store_q | (pte.w & pte.d));
    end
  end

  always_comb begin
    go_next    = 1'b0;
    take_fault = 1'b1;
    cause      = ptw_pkg::FAULT_INVALID;
    if (!pte.v || (!pte.r && pte.w)) begin
      cause = ptw_pkg::FAULT_INVALID;
    end else if (is_leaf) begin
      if (misaligned) begin
        cause = ptw_pkg::FAULT_MISALIGNED;
      end else if (!perm_ok) begin
        cause = ptw_pkg::FAULT_PERMISSION;
      end else begin
        take_fault = 1'b0;
      end
    end else if (lvl_q) begin
      // sv32 has no third level
      cause = ptw_pkg::FAULT_TOO_DEEP;
    end else begin
      go_next    = 1'b1;
      take_fault = 1'b0;
    end
  end

  // both views of the result word
  assign xlat_v = '{ppn: pte.ppn, is_4m: ~lvl_q, d: pte.d, a: pte.a, u: pte.u,
                    x: pte.x, w: pte.w, r: pte.r, pad: 3'b000};
  assign fault_v = '{cause: cause, level: lvl_q, pte_bits: rdata_q[31:4]};

  // ------------------------------
  // walk fsm
  // ------------------------------
  always_comb begin
    state_d  = state_q;
    lvl_d    = lvl_q;
    pptr_d   = pptr_q;
    result_d = result_q;
    fault_d  = fault_q;
    case (state_q)
      S_IDLE: begin
        if (start_i) begin
          // satp.ppn * 4096 + vpn[1] * 4
          lvl_d   = 1'b0;
          pptr_d  = {satp_ppn_i, vaddr_i[31:22], 2'b00};
          state_d = S_REQUEST;
        end
      end
      S_REQUEST: begin
        if (mem_gnt_i) state_d = S_LOOKUP;
      end
      S_LOOKUP: begin
        // registered read data, checked one cycle after rvalid
        if (rvalid_q) begin
          if (go_next) begin
            lvl_d   = 1'b1;
            pptr_d  = {pte.ppn, vaddr_q[21:12], 2'b00};
            state_d = S_REQUEST;
          end else if (take_fault) begin
            result_d.fault = fault_v;
            fault_d        = 1'b1;
            state_d        = S_ERROR;
          end else begin
            result_d.xlat = xlat_v;
            fault_d       = 1'b0;
            state_d       = S_DONE;
          end
        end
      end
      S_ERROR: begin
        state_d = S_DONE;
      end
      S_DONE: begin
        // hold the result until the collector takes it
        if (pop_i) state_d = S_IDLE;
      end
      default: begin
        state_d = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= S_IDLE;
      lvl_q    <= 1'b0;
      fault_q  <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      lvl_q    <= lvl_d;
      fault_q  <= fault_d;
      rvalid_q <= mem_rvalid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    pptr_q   <= pptr_d;
    result_q <= result_d;
    // rdata is shared by all walkers, take it only on our own rvalid
    if (mem_rvalid_i) rdata_q <= mem_rdata_i;
    if (state_q == S_IDLE && start_i) begin
      vaddr_q <= vaddr_i;
      store_q <= store_i;
      instr_q <= instr_i;
    end
  end

  assign busy_o     = (state_q != S_IDLE);
  assign mem_req_o  = (state_q == S_REQUEST);
  assign mem_addr_o = pptr_q;
  assign done_o     = (state_q == S_DONE);
  assign result_o   = result_q;
  assign is_fault_o = fault_q;
  assign vaddr_o    = vaddr_q;

endmodule

/* ptw_miss_dispatch.sv */
module ptw_miss_dispatch #(
  parameter int NUM_WALKERS = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     miss_valid_i,
  input  logic [ptw_pkg::VLEN-1:0] miss_vaddr_i,
  input  logic                     miss_store_i,
  input  logic                     miss_instr_i,
  input  logic [NUM_WALKERS-1:0]   walker_busy_i,
  input  logic [NUM_WALKERS-1:0]   walker_pop_i,
  output logic [NUM_WALKERS-1:0]   start_o,
  output logic [ptw_pkg::VLEN-1:0] start_vaddr_o,
  output logic                     start_store_o,
  output logic                     start_instr_o,
  output logic                     miss_credit_o
);

  logic [NUM_WALKERS-1:0]   start_q;
  logic [NUM_WALKERS-1:0]   pick;
  logic [ptw_pkg::VLEN-1:0] vaddr_q;
  logic                     store_q;
  logic                     instr_q;
  logic                     credit_q;

  // lowest idle walker wins
  // a walker started last cycle still shows busy low, so skip it
  always_comb begin
    pick = '0;
    for (int i = NUM_WALKERS - 1; i >= 0; i--) begin
      if (!walker_busy_i[i] && !start_q[i]) begin
        pick    = '0;
        pick[i] = 1'b1;
      end
    end
  end

  // start pulse and credit return
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      start_q  <= miss_valid_i ? pick : '0;
      // collector pops at most one walker per cycle
      credit_q <= |walker_pop_i;
    end
  end

  // miss payload, broadcast to all walkers
  always_ff @(posedge clk_i) begin
    if (miss_valid_i) begin
      vaddr_q <= miss_vaddr_i;
      store_q <= miss_store_i;
      instr_q <= miss_instr_i;
    end
  end

  assign start_o       = start_q;
  assign start_vaddr_o = vaddr_q;
  assign start_store_o = store_q;
  assign start_instr_o = instr_q;
  assign miss_credit_o = credit_q;

endmodule

/* ptw_pkg.sv */
package ptw_pkg;

  // ------------------------------
  // address widths
  // ------------------------------
  // sv32 virtual address
  localparam int VLEN = 32;
  // physical address, 22-bit ppn plus 12-bit page offset
  localparam int PLEN = 34;
  localparam int PPNW = 22;

  // sv32 page table entry as read from memory
  typedef struct packed {
    logic [21:0] ppn;
    logic [1:0]  rsw;
    logic        d;
    logic        a;
    logic        g;
    logic        u;
    logic        x;
    logic        w;
    logic        r;
    logic        v;
  } pte_t;

  // page fault reason, zero is left unused
  typedef enum logic [2:0] {
    FAULT_INVALID    = 3'd1,
    FAULT_MISALIGNED = 3'd2,
    FAULT_TOO_DEEP   = 3'd3,
    FAULT_PERMISSION = 3'd4
  } fault_cause_e;

  // ------------------------------
  // result word, two views
  // ------------------------------
  // successful walk
  typedef struct packed {
    logic [21:0] ppn;
    logic        is_4m;
    logic        d;
    logic        a;
    logic        u;
    logic        x;
    logic        w;
    logic        r;
    logic [2:0]  pad;
  } xlat_t;

  // page fault, level 1 is the second level
  typedef struct packed {
    fault_cause_e cause;
    logic         level;
    logic [27:0]  pte_bits;
  } fault_t;

  // is_fault beside the word picks the view
  typedef union packed {
    xlat_t  xlat;
    fault_t fault;
  } walk_result_u;

endpackage
